// File: pov_panel.f
+incdir+design
design/panel_pkg.sv
design/host_pkg.sv
design/host_regs.sv
design/frame_memory.sv
design/scan_sequencer.sv
design/hub75_output.sv
design/pov_panel_top.sv
tb/pov_panel_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the POV panel testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log
BIN=pov_panel_sim

verilator --binary --timing -f pov_panel.f --top-module pov_panel_tb \
   -Mdir "$BUILD_DIR" -o "$BIN"
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

"./$BUILD_DIR/$BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if grep -q "^RESULT: PASS$" "$LOG"; then
   exit 0
fi
echo "pass line not found in $LOG"
exit 1

// File: tb/pov_panel_tb.sv
`include "pov_panel_settings.svh"

module pov_panel_tb;

   // longest line at unit 15, three planes of shift + latch, 7 units lit
   localparam int LINE_MAX    = 3 * (2 * `PANEL_COLS + 1) + 7 * 15 + 8;
   localparam int MAX_LINES   = 80;
   localparam int MAX_WRITES  = 300;
   localparam int CYCLE_LIMIT = MAX_LINES * LINE_MAX + MAX_WRITES * 4 + 3 * LINE_MAX + 500;

   logic                 clk_in;
   logic                 rst_in;
   logic                 host_req;
   host_pkg::host_sel_e  host_sel;
   host_pkg::pix_addr_t  host_addr;
   logic [`PIX_BITS-1:0] host_wdata;
   logic                 host_ack;
   logic [2:0]           rgb0;
   logic [2:0]           rgb1;
   logic                 led_clk;
   logic                 led_latch;
   logic                 led_output_enable;
   panel_pkg::row_t      hub75_address;

   int seed;
   int cycles;

   // host side model, updated at ack
   logic [`PIX_BITS-1:0]  frame [2][`SCAN_ROWS][`PANEL_COLS];
   logic [`UNIT_BITS-1:0] model_unit;

   // panel side model, rebuilt from led_clk / led_latch
   panel_pkg::pixel_u          snap [2][`PANEL_COLS];   // line as shown
   panel_pkg::row_t            exp_row;
   panel_pkg::col_t            col_idx;
   logic [`DISP_BITS-1:0]      line_unit;
   logic [`DISP_BITS-1:0]      lit;                     // lit cycles this plane
   logic [$clog2(`PLANES)-1:0] plane;
   logic [$clog2(`PLANES)-1:0] latch_plane;
   int                         col_cnt;
   int                         latch_count;
   int                         lines_done;
   logic                       prev_clk;
   logic                       in_disp;
   logic                       line_open;

   pov_panel_top dut (
      .clk_in            (clk_in),
      .rst_in            (rst_in),
      .host_req          (host_req),
      .host_sel          (host_sel),
      .host_addr         (host_addr),
      .host_wdata        (host_wdata),
      .host_ack          (host_ack),
      .rgb0              (rgb0),
      .rgb1              (rgb1),
      .led_clk           (led_clk),
      .led_latch         (led_latch),
      .led_output_enable (led_output_enable),
      .hub75_address     (hub75_address)
   );

   task automatic stop_run(input string msg);
      $display("%s", msg);
      $display("RESULT: FAIL");
      $fatal(1, "run stopped at the first error");
   endtask

   // plane p of each channel, red on bit 0
   task automatic check_pixel_bits(input string name, input logic [2:0] got,
                                   input panel_pkg::chan_t pix,
                                   input logic [$clog2(`PLANES)-1:0] p);
      logic [2:0] exp;
      exp = {pix.b[p], pix.g[p], pix.r[p]};
      if (got !== exp) begin
         stop_run($sformatf("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp));
      end
   endtask

   task automatic check_row(input string name, input panel_pkg::row_t got,
                            input panel_pkg::row_t exp);
      if (got !== exp) begin
         stop_run($sformatf("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp));
      end
   endtask

   task automatic check_count(input string name, input logic [`DISP_BITS-1:0] got,
                              input logic [`DISP_BITS-1:0] exp);
      if (got !== exp) begin
         stop_run($sformatf("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp));
      end
   endtask

   // cycles for one full line, zero unit runs as one
   function automatic int line_cycles(input logic [`UNIT_BITS-1:0] u);
      int ue;
      ue = (u == '0) ? 1 : int'(u);
      return 3 * (2 * `PANEL_COLS + 1) + 7 * ue + 4;
   endfunction

   // four-phase write, called on a falling edge
   task automatic host_write(input host_pkg::host_sel_e sel, input host_pkg::pix_addr_t addr,
                             input logic [`PIX_BITS-1:0] data);
      int waited;
      if (host_ack !== 1'b0) stop_run("host_ack was high before host_req was raised");
      host_sel   = sel;
      host_addr  = addr;
      host_wdata = data;
      host_req   = 1'b1;
      waited     = 0;
      do begin
         @(negedge clk_in);
         waited++;
         if (waited > 8) stop_run("host_ack never rose after host_req");
      end while (host_ack !== 1'b1);
      if (sel == host_pkg::SEL_CTRL) begin   // unit above enable
         model_unit = data[`CTRL_BITS-1:1];
      end else begin
         frame[addr.half][addr.row][addr.col] = data;
      end
      @(negedge clk_in);   // req still high, ack must hold
      if (host_ack !== 1'b1) stop_run("host_ack dropped while host_req was still high");
      host_req = 1'b0;
      waited   = 0;
      do begin
         @(negedge clk_in);
         waited++;
         if (waited > 8) stop_run("host_ack never fell after host_req dropped");
      end while (host_ack !== 1'b0);
   endtask

   task automatic write_pixel(input logic half, input panel_pkg::row_t row,
                              input panel_pkg::col_t col, input logic [`PIX_BITS-1:0] data);
      host_pkg::pix_addr_t addr;
      addr.half = half;
      addr.row  = row;
      addr.col  = col;
      host_write(host_pkg::SEL_PIXEL, addr, data);
   endtask

   task automatic write_ctrl(input logic en, input logic [`UNIT_BITS-1:0] u);
      host_write(host_pkg::SEL_CTRL, '0, {u, en});
   endtask

   task automatic wait_lines(input int n);
      int target;
      target = lines_done + n;
      while (lines_done < target) @(negedge clk_in);
   endtask

   // returns on the falling edge right after a latch of plane p
   task automatic wait_latch(input int p);
      int start;
      do begin
         start = latch_count;
         @(negedge clk_in);
      end while (!(latch_count != start && int'(latch_plane) == p));
   endtask

   initial begin
      clk_in = 1'b0;
      forever #2 clk_in = ~clk_in;
   end

   // panel monitor, samples the cycle that just ended
   always @(posedge clk_in) begin
      if (!rst_in) begin
         if (led_clk && !prev_clk) begin   // column clocked in
            if (in_disp) stop_run("led_clk pulsed while the panel was lit");
            if (!line_open) begin          // first column of a new line
               line_open = 1'b1;
               plane     = '0;
               line_unit = (model_unit == '0) ? {{(`DISP_BITS-1){1'b0}}, 1'b1}
                                              : {{(`PLANES-1){1'b0}}, model_unit};
               for (int c = 0; c < `PANEL_COLS; c++) begin
                  snap[0][c].bits = frame[0][exp_row][c];
                  snap[1][c].bits = frame[1][exp_row][c];
               end
            end
            if (col_cnt >= `PANEL_COLS) stop_run("more led_clk pulses than columns before latch");
            col_idx = panel_pkg::col_t'(col_cnt);
            check_pixel_bits($sformatf("rgb0 row %0d col %0d", exp_row, col_idx),
                             rgb0, snap[0][col_idx].chan, plane);
            check_pixel_bits($sformatf("rgb1 row %0d col %0d", exp_row, col_idx),
                             rgb1, snap[1][col_idx].chan, plane);
            col_cnt++;
         end
         if (led_latch) begin
            if (col_cnt != `PANEL_COLS) begin
               stop_run($sformatf("led_latch came after %0d column clocks", col_cnt));
            end
            check_row("hub75_address", hub75_address, exp_row);
            in_disp     = 1'b1;
            lit         = '0;
            latch_plane = plane;
            latch_count++;
         end else if (in_disp) begin
            if (!led_output_enable) begin
               lit = lit + 1'b1;
            end else if (lit == '0) begin
               stop_run("led_output_enable did not drop after the latch");
            end else begin   // plane done, compare lit time
               check_count("led_output_enable low cycles", lit, line_unit << plane);
               in_disp = 1'b0;
               col_cnt = 0;
               if (plane == `PLANES - 1) begin
                  line_open = 1'b0;
                  exp_row   = (exp_row == panel_pkg::row_t'(`SCAN_ROWS - 1)) ? '0
                                                                             : exp_row + 1'b1;
                  lines_done++;
               end else begin
                  plane = plane + 1'b1;
               end
            end
         end else if (!led_output_enable) begin
            stop_run("led_output_enable low outside the display phase");
         end
         prev_clk = led_clk;
      end
   end

   always @(posedge clk_in) begin
      cycles = cycles + 1;
      if (cycles > CYCLE_LIMIT) begin
         stop_run($sformatf("timeout after %0d cycles, the scan did not finish", cycles));
      end
   end

   initial begin
      logic [`PIX_BITS-1:0]  word;
      logic [`UNIT_BITS-1:0] u;
      panel_pkg::col_t       col_pick;
      int                    rnd;
      seed         = 3226;
      cycles       = 0;
      rst_in       = 1'b1;
      host_req     = 1'b0;
      host_sel     = host_pkg::SEL_CTRL;
      host_addr    = '0;
      host_wdata   = '0;
      model_unit   = `UNIT_BITS'(1);   // control reset value
      exp_row      = '0;
      plane        = '0;
      latch_plane  = '0;
      col_cnt      = 0;
      latch_count  = 0;
      lines_done   = 0;
      prev_clk     = 1'b0;
      in_disp      = 1'b0;
      line_open    = 1'b0;
      repeat (10) @(posedge clk_in);
      @(negedge clk_in);
      rst_in = 1'b0;
      @(negedge clk_in);
      if (led_clk !== 1'b0 || led_latch !== 1'b0 || led_output_enable !== 1'b1 ||
          host_ack !== 1'b0) begin
         stop_run("panel outputs or host_ack not idle after reset");
      end
      check_row("hub75_address", hub75_address, '0);

      // whole frame random, scan still off
      for (int h = 0; h < 2; h++) begin
         for (int r = 0; r < `SCAN_ROWS; r++) begin
            for (int c = 0; c < `PANEL_COLS; c++) begin
               rnd  = $random(seed);
               word = rnd[`PIX_BITS-1:0];
               write_pixel(h[0], panel_pkg::row_t'(r), panel_pkg::col_t'(c), word);
            end
         end
      end
      write_ctrl(1'b1, `UNIT_BITS'(3));
      wait_lines(`SCAN_ROWS);

      // new unit during the last plane, next line picks it up; first one is zero
      for (int i = 0; i < 6; i++) begin
         rnd = $random(seed);
         u   = (i == 0) ? '0 : {{(`UNIT_BITS-4){1'b0}}, rnd[3:0]};
         wait_latch(2);
         write_ctrl(1'b1, u);
         wait_lines(2);
      end

      // rewrite pixels of the row on show, seen next time round
      for (int i = 0; i < 6; i++) begin
         wait_latch(0);
         rnd      = $random(seed);
         col_pick = rnd[$clog2(`PANEL_COLS)-1:0];
         word     = rnd[`PIX_BITS+7:8];
         write_pixel(rnd[20], exp_row, col_pick, word);
      end
      wait_lines(2 * `SCAN_ROWS);

      // scan off, line in flight and the held one may still finish
      wait_latch(1);
      write_ctrl(1'b0, model_unit);
      repeat (2 * line_cycles(model_unit)) @(negedge clk_in);
      if (line_open || in_disp) stop_run("scan still running two line times after disable");
      repeat (line_cycles(model_unit)) begin
         @(negedge clk_in);
         if (led_clk !== 1'b0 || led_latch !== 1'b0) begin
            stop_run("led_clk or led_latch active while the scan was disabled");
         end
         if (led_output_enable !== 1'b1) stop_run("panel lit while the scan was disabled");
      end

      // back on, rows carry on from where they stopped
      rnd = $random(seed);
      write_ctrl(1'b1, {{(`UNIT_BITS-4){1'b0}}, rnd[3:0]});
      wait_lines(10);
      $display("RESULT: PASS");
      $finish;
   end

endmodule

// File: design/pov_panel_top.sv
`include "pov_panel_settings.svh"

module pov_panel_top (
   input  logic                 clk_in,
   input  logic                 rst_in,
   // host port, four-phase
   input  logic                 host_req,
   input  host_pkg::host_sel_e  host_sel,
   input  host_pkg::pix_addr_t  host_addr,
   input  logic [`PIX_BITS-1:0] host_wdata,
   output logic                 host_ack,
   // HUB75 panel
   output logic [2:0]           rgb0,
   output logic [2:0]           rgb1,
   output logic                 led_clk,
   output logic                 led_latch,
   output logic                 led_output_enable,
   output panel_pkg::row_t      hub75_address
);

   logic                 pix_we;
   host_pkg::pix_addr_t  pix_addr;
   panel_pkg::pixel_u    pix_data;
   host_pkg::ctrl_t      ctrl;
   panel_pkg::row_t      rd_row;
   panel_pkg::row_pair_t rd_data;
   logic                 line_valid;
   logic                 line_ready;
   panel_pkg::row_pair_t line_data;
   panel_pkg::row_t      line_row;

   host_regs u_host_regs (
      .clk_in     (clk_in),
      .rst_in     (rst_in),
      .host_req   (host_req),
      .host_sel   (host_sel),
      .host_addr  (host_addr),
      .host_wdata (host_wdata),
      .host_ack   (host_ack),
      .pix_we     (pix_we),
      .pix_addr   (pix_addr),
      .pix_data   (pix_data),
      .ctrl       (ctrl)
   );

   frame_memory u_frame_memory (
      .clk_in   (clk_in),
      .pix_we   (pix_we),
      .pix_addr (pix_addr),
      .pix_data (pix_data),
      .rd_row   (rd_row),
      .rd_data  (rd_data)
   );

   scan_sequencer u_scan_sequencer (
      .clk_in     (clk_in),
      .rst_in     (rst_in),
      .enable     (ctrl.enable),
      .rd_data    (rd_data),
      .line_ready (line_ready),
      .rd_row     (rd_row),
      .line_valid (line_valid),
      .line_data  (line_data),
      .line_row   (line_row)
   );

   hub75_output u_hub75_output (
      .clk_in            (clk_in),
      .rst_in            (rst_in),
      .line_valid        (line_valid),
      .line_data         (line_data),
      .line_row          (line_row),
      .unit              (ctrl.unit),
      .line_ready        (line_ready),
      .rgb0              (rgb0),
      .rgb1              (rgb1),
      .led_clk           (led_clk),
      .led_latch         (led_latch),
      .led_output_enable (led_output_enable),
      .hub75_address     (hub75_address)
   );

endmodule

// File: design/hub75_output.sv
`include "pov_panel_settings.svh"

module hub75_output (
   input  logic                  clk_in,
   input  logic                  rst_in,
   input  logic                  line_valid,
   input  panel_pkg::row_pair_t  line_data,
   input  panel_pkg::row_t       line_row,
   input  logic [`UNIT_BITS-1:0] unit,
   output logic                  line_ready,
   output logic [2:0]            rgb0,
   output logic [2:0]            rgb1,
   output logic                  led_clk,
   output logic                  led_latch,
   output logic                  led_output_enable,
   output panel_pkg::row_t       hub75_address
);

   typedef enum logic [1:0] {
      O_IDLE,      // wait for a line
      O_SHIFT,     // two cycles per column
      O_LATCH,     // one cycle, address moves here
      O_DISPLAY    // panel lit for unit << plane
   } ostate_e;

   ostate_e                    ostate;
   panel_pkg::row_pair_t       line_q;     // accepted line
   panel_pkg::row_t            row_q;
   logic [`UNIT_BITS-1:0]      unit_q;     // one unit per line
   logic [`DISP_BITS-1:0]      unit_ext;
   panel_pkg::col_t            col;
   logic [$clog2(`PLANES)-1:0] plane;
   logic [`DISP_BITS-1:0]      disp_cnt;
   logic                       accept;
   panel_pkg::pixel_u          top_pix;
   panel_pkg::pixel_u          bot_pix;

   assign line_ready = (ostate == O_IDLE);
   assign accept     = line_ready && line_valid;
   assign unit_ext   = {{(`PLANES-1){1'b0}}, unit_q};

   // current column of each half
   assign top_pix = line_q[0][col];
   assign bot_pix = line_q[1][col];

   // plane p of each channel, red on bit 0
   assign rgb0 = {top_pix.chan.b[plane], top_pix.chan.g[plane], top_pix.chan.r[plane]};
   assign rgb1 = {bot_pix.chan.b[plane], bot_pix.chan.g[plane], bot_pix.chan.r[plane]};

   always_ff @(posedge clk_in) begin
      if (rst_in) begin
         ostate            <= O_IDLE;
         col               <= '0;
         plane             <= '0;
         disp_cnt          <= '0;
         led_clk           <= 1'b0;
         led_latch         <= 1'b0;
         led_output_enable <= 1'b1;   // blanked
         hub75_address     <= '0;
      end else begin
         case (ostate)
            O_IDLE: begin
               if (line_valid) begin
                  ostate  <= O_SHIFT;
                  col     <= '0;
                  plane   <= '0;
                  led_clk <= 1'b0;
               end
            end
            O_SHIFT: begin
               // led_clk doubles as the half-column phase
               if (!led_clk) begin
                  led_clk <= 1'b1;   // data stable since last cycle
               end else begin
                  led_clk <= 1'b0;
                  if (col == panel_pkg::col_t'(`PANEL_COLS - 1)) begin
                     ostate        <= O_LATCH;
                     led_latch     <= 1'b1;
                     hub75_address <= row_q;
                  end else begin
                     col <= col + 1'b1;
                  end
               end
            end
            O_LATCH: begin
               led_latch         <= 1'b0;
               led_output_enable <= 1'b0;                // lit from next cycle
               disp_cnt          <= unit_ext << plane;   // binary weight 1, 2, 4
               ostate            <= O_DISPLAY;
            end
            O_DISPLAY: begin
               if (disp_cnt == 1) begin   // last lit cycle
                  led_output_enable <= 1'b1;
                  col               <= '0;
                  if (plane == `PLANES - 1) begin
                     ostate <= O_IDLE;   // ready next cycle
                  end else begin
                     plane  <= plane + 1'b1;
                     ostate <= O_SHIFT;
                  end
               end else begin
                  disp_cnt <= disp_cnt - 1'b1;
               end
            end
            default: begin
               ostate <= O_IDLE;
            end
         endcase
      end
   end

   // line payload, taken on the transfer
   always_ff @(posedge clk_in) begin
      if (accept) begin
         line_q <= line_data;
         row_q  <= line_row;
         // zero unit would never light, run it as one
         unit_q <= (unit == '0) ? {{(`UNIT_BITS-1){1'b0}}, 1'b1} : unit;
      end
   end

endmodule

// File: design/scan_sequencer.sv
`include "pov_panel_settings.svh"

module scan_sequencer (
   input  logic                 clk_in,
   input  logic                 rst_in,
   input  logic                 enable,
   input  panel_pkg::row_pair_t rd_data,
   input  logic                 line_ready,
   output panel_pkg::row_t      rd_row,
   output logic                 line_valid,
   output panel_pkg::row_pair_t line_data,
   output panel_pkg::row_t      line_row
);

   typedef enum logic [1:0] {
      S_READ,      // address on rd_row, memory reads this edge
      S_PRESENT,   // rd_data valid, capture when enabled
      S_HOLD       // valid up, wait for ready
   } sstate_e;

   sstate_e         sstate;
   panel_pkg::row_t cur_row;
   panel_pkg::row_t next_row;
   logic            capture;

   assign rd_row   = cur_row;   // memory always reads the current row
   assign next_row = (cur_row == panel_pkg::row_t'(`SCAN_ROWS - 1)) ? '0 : cur_row + 1'b1;
   assign capture  = (sstate == S_PRESENT) && enable;

   always_ff @(posedge clk_in) begin
      if (rst_in) begin
         sstate     <= S_READ;
         cur_row    <= '0;
         line_valid <= 1'b0;
      end else begin
         case (sstate)
            S_READ: begin
               sstate <= S_PRESENT;
            end
            S_PRESENT: begin
               // stays here while disabled, memory keeps refreshing rd_data
               if (enable) begin
                  line_valid <= 1'b1;
                  sstate     <= S_HOLD;
               end
            end
            S_HOLD: begin
               if (line_ready) begin   // transfer on this edge
                  line_valid <= 1'b0;
                  cur_row    <= next_row;
                  sstate     <= S_READ;
               end
            end
            default: begin
               sstate <= S_READ;
            end
         endcase
      end
   end

   // line held stable across the handshake
   always_ff @(posedge clk_in) begin
      if (capture) begin
         line_data <= rd_data;
         line_row  <= cur_row;
      end
   end

endmodule

// File: design/frame_memory.sv
`include "pov_panel_settings.svh"

module frame_memory (
   input  logic                 clk_in,
   input  logic                 pix_we,
   input  host_pkg::pix_addr_t  pix_addr,
   input  panel_pkg::pixel_u    pix_data,
   input  panel_pkg::row_t      rd_row,
   output panel_pkg::row_pair_t rd_data
);

   // one bank per panel half
   // host writes one pixel, the scan side reads a whole row of both banks
   for (genvar h = 0; h < 2; h++) begin : g_half
      panel_pkg::pixel_u bank [`SCAN_ROWS][`PANEL_COLS];
      logic              we_half;

      assign we_half = pix_we && (pix_addr.half == h[0]);   // half select

      always_ff @(posedge clk_in) begin
         if (we_half) begin
            bank[pix_addr.row][pix_addr.col] <= pix_data;
         end
      end

      // registered row read, old data on a same-cycle write
      always_ff @(posedge clk_in) begin
         for (int c = 0; c < `PANEL_COLS; c++) begin
            rd_data[h][c] <= bank[rd_row][c];
         end
      end
   end

endmodule

// File: design/host_regs.sv
`include "pov_panel_settings.svh"

module host_regs (
   input  logic                 clk_in,
   input  logic                 rst_in,
   input  logic                 host_req,
   input  host_pkg::host_sel_e  host_sel,
   input  host_pkg::pix_addr_t  host_addr,
   input  logic [`PIX_BITS-1:0] host_wdata,
   output logic                 host_ack,
   output logic                 pix_we,
   output host_pkg::pix_addr_t  pix_addr,
   output panel_pkg::pixel_u    pix_data,
   output host_pkg::ctrl_t      ctrl
);

   // four-phase slave
   // idle waits for req, ack holds until req drops
   typedef enum logic {
      H_IDLE,
      H_ACK
   } hstate_e;

   hstate_e hstate;
   logic    take;     // req seen in idle, write this edge

   assign take     = (hstate == H_IDLE) && host_req;
   assign host_ack = (hstate == H_ACK);   // one cycle after req first seen

   always_ff @(posedge clk_in) begin
      if (rst_in) begin
         hstate <= H_IDLE;
         pix_we <= 1'b0;
         // scan off, unit of one
         ctrl.enable <= 1'b0;
         ctrl.unit   <= {{(`UNIT_BITS-1){1'b0}}, 1'b1};
      end else begin
         pix_we <= 1'b0;   // strobe, one cycle only
         case (hstate)
            H_IDLE: begin
               if (host_req) begin
                  hstate <= H_ACK;
                  if (host_sel == host_pkg::SEL_CTRL) begin
                     // unit in [8:1], enable in [0]
                     ctrl <= host_pkg::ctrl_t'(host_wdata[`CTRL_BITS-1:0]);
                  end else begin
                     pix_we <= 1'b1;   // frame memory takes it this cycle
                  end
               end
            end
            H_ACK: begin
               if (!host_req) begin
                  hstate <= H_IDLE;   // ack falls next cycle
               end
            end
            default: begin
               hstate <= H_IDLE;
            end
         endcase
      end
   end

   // pixel payload, sampled with the request
   always_ff @(posedge clk_in) begin
      if (take) begin
         pix_addr      <= host_addr;
         pix_data.bits <= host_wdata;   // flat view on the write side
      end
   end

endmodule

// File: design/host_pkg.sv
`include "pov_panel_settings.svh"

package host_pkg;

   // what a host write addresses
   typedef enum logic {
      SEL_CTRL  = 1'b0,     // control register
      SEL_PIXEL = 1'b1      // one pixel of the frame
   } host_sel_e;

   // control word, enable in bit 0
   typedef struct packed {
      logic [`UNIT_BITS-1:0] unit;     // base plane time, zero acts as one
      logic                  enable;   // scan on/off
   } ctrl_t;

   // pixel write target
   typedef struct packed {
      logic            half;   // 0 upper, 1 lower
      panel_pkg::row_t row;
      panel_pkg::col_t col;
   } pix_addr_t;

endpackage

// File: design/panel_pkg.sv
`include "pov_panel_settings.svh"

package panel_pkg;

   // one colour split by channel, r in the low bits
   typedef struct packed {
      logic [`PLANES-1:0] b;
      logic [`PLANES-1:0] g;
      logic [`PLANES-1:0] r;
   } chan_t;

   // the same word seen two ways
   // bits for storage and host writes, chan for plane selection
   typedef union packed {
      logic [`PIX_BITS-1:0] bits;
      chan_t                chan;
   } pixel_u;

   typedef logic [$clog2(`PANEL_COLS)-1:0] col_t;   // column within a row
   typedef logic [$clog2(`SCAN_ROWS)-1:0]  row_t;   // scan address, drives hub75_address

   // one scan line for both halves
   // index [0] is the upper half, [1] the lower half
   typedef pixel_u [1:0][`PANEL_COLS-1:0] row_pair_t;

endpackage

// File: design/pov_panel_settings.svh
`ifndef POV_PANEL_SETTINGS_SVH
`define POV_PANEL_SETTINGS_SVH

// panel geometry, one HUB75 panel
`define PANEL_COLS 16             // pixels per row
`define SCAN_ROWS  8              // scan rows per half, 16 rows on the panel
`define PLANES     3              // bit planes per colour channel

// pixel word, r g b side by side
`define PIX_BITS   (3 * `PLANES)

// control word, unit above the enable bit
`define UNIT_BITS  8              // display time unit in clocks
`define CTRL_BITS  (`UNIT_BITS + 1)

// display counter must hold unit << (PLANES-1)
`define DISP_BITS  (`UNIT_BITS + `PLANES - 1)

`endif
